/* flist.f */
+incdir+logic
logic/stackPkg.sv
logic/commandDecoder.sv
logic/operandStack.sv
logic/statusReporter.sv
logic/stackUnit.sv
verification/stackUnitTb.sv

/* verification/stackUnitTb.sv */
`timescale 1ns/100ps

`include "stack_cfg.svh"

module stackUnitTb
  import stackPkg::*;
();

  localparam int totalCommands = 48; // Sum over the six tests

  typedef struct packed {
    logic                          valid;
    logic [`STACK_INDEX_WIDTH-1:0] index;
    logic [`STACK_DATA_WIDTH-1:0]  top;
    logic                          topKnown;
    stackStatus_e                  status;
    logic                          pulse;
    logic [7:0]                    count;
  } checkPoint_s;

  logic                          clk;
  logic                          reset;
  logic                          cmdValid;
  cmdWord_s                      cmd;
  logic [`STACK_INDEX_WIDTH-1:0] stackIndex;
  logic [`STACK_DATA_WIDTH-1:0]  stackTop;
  stackStatus_e                  status;
  logic                          errorPulse;
  logic [7:0]                    errorCount;

  // Reference stack
  logic [`STACK_DATA_WIDTH-1:0] modelMem [`STACK_CAPACITY];
  logic [`STACK_CAPACITY-1:0]   memKnown;
  logic [`STACK_DATA_WIDTH-1:0] modelTop;
  logic                         topKnown;
  int                           modelIndex;
  int                           modelLimit;
  int                           modelErrors;

  // Expected results travel two edges behind their command
  checkPoint_s expNow;
  checkPoint_s pipeA;
  checkPoint_s pipeB;

  string  testName;
  int     failCount;
  int     failAtStart;
  int     passTests;
  int     failTests;
  int     pulseSeen;
  integer seed;

  stackUnit UUT (
    .clk        (clk),
    .reset      (reset),
    .cmdValid   (cmdValid),
    .cmd        (cmd),
    .stackIndex (stackIndex),
    .stackTop   (stackTop),
    .status     (status),
    .errorPulse (errorPulse),
    .errorCount (errorCount)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) begin
      pipeA <= '0;
      pipeB <= '0;
    end else begin
      pipeA <= expNow;
      pipeB <= pipeA;
    end
  end

  always @(negedge clk) begin
    if (!reset && errorPulse) begin
      pulseSeen++;
    end
  end

  function automatic stackStatus_e statusRule(input int idx, input int limit);
    if (idx == `STACK_CAPACITY) begin
      return statFull;
    end else if (idx == limit) begin
      return statEmpty;
    end else if (idx < limit) begin
      return statUnderflow;
    end
    return statNone;
  endfunction

  task automatic reportMismatch(input string what, input int expected, input int actual);
    $display("MISMATCH %s %s: expected %0d actual %0d", testName, what, expected, actual);
    failCount++;
  endtask

  task automatic writeSlot(input int slot, input int data);
    modelMem[slot] = data[`STACK_DATA_WIDTH-1:0];
    memKnown[slot] = 1'b1;
  endtask

  task automatic setTop(input int data);
    modelTop = data[`STACK_DATA_WIDTH-1:0];
    topKnown = 1'b1;
  endtask

  // Slot -1 means an empty stack, whose top is undefined
  task automatic readTop(input int slot);
    if (slot >= 0 && memKnown[slot]) begin
      modelTop = modelMem[slot];
      topKnown = 1'b1;
    end else begin
      topKnown = 1'b0;
    end
  endtask

  task automatic stepModel(input cmdOp_e op, input int data, input int pos, input bit checked);
    stackStatus_e st;
    bit           realCmd;
    bit           isErr;
    st      = statusRule(modelIndex, modelLimit);
    realCmd = (op != cmdNone) && (op != cmdSetLimit);
    case (op)
      cmdPush: begin
        if (modelIndex == `STACK_CAPACITY) begin
          st = statOverflow;
        end else begin
          writeSlot(modelIndex, data);
          modelIndex++;
          setTop(data);
          st = statusRule(modelIndex, modelLimit);
        end
      end
      cmdPop: begin
        if (modelIndex <= data + modelLimit) begin
          st = statUnderflow;
        end else begin
          modelIndex = modelIndex - data - 1; // Count plus one entries leave
          readTop(modelIndex - 1);
          st = statusRule(modelIndex, modelLimit);
        end
      end
      cmdReplace: begin
        if (modelIndex <= modelLimit) begin
          st = statUnderflow;
        end else begin
          writeSlot(modelIndex - 1, data);
          setTop(data);
        end
      end
      cmdIndexReset: begin
        if (pos > modelIndex) begin
          st = statBadIndex;
        end else begin
          modelIndex = pos;
          readTop(pos - 1);
          st = statusRule(modelIndex, modelLimit);
        end
      end
      cmdIndexResetPush: begin
        if (pos > modelIndex) begin
          st = statBadIndex;
        end else if (pos == `STACK_CAPACITY) begin
          st = statOverflow;
        end else begin
          writeSlot(pos, data);
          modelIndex = pos + 1;
          setTop(data);
          st = statusRule(modelIndex, modelLimit);
        end
      end
      cmdPeek: begin
        if (pos >= modelIndex) begin
          st = statBadOffset;
        end else begin
          readTop(pos);
          st = statNone;
        end
      end
      cmdPoke: begin
        if (pos >= modelIndex) begin
          st = statBadOffset;
        end else begin
          writeSlot(pos, data);
          if (pos == modelIndex - 1) begin
            setTop(data);
          end
        end
      end
      default: begin
        readTop(modelIndex - 1); // Idle refresh uses the old limit for cmdSetLimit
      end
    endcase
    if (op == cmdSetLimit) begin
      modelLimit = pos;
    end
    isErr = realCmd && (st inside {statOverflow, statUnderflow, statBadIndex, statBadOffset});
    if (isErr && modelErrors < 255) begin
      modelErrors++;
    end
    expNow.valid    = checked;
    expNow.index    = modelIndex[`STACK_INDEX_WIDTH-1:0];
    expNow.top      = modelTop;
    expNow.topKnown = topKnown;
    expNow.status   = st;
    expNow.pulse    = isErr;
    expNow.count    = modelErrors[7:0];
  endtask

  task automatic issueCommand(input cmdOp_e op, input logic [7:0] data, input logic [4:0] pos);
    @(negedge clk);
    cmd.opcode = op;
    if (op == cmdSetLimit) begin
      cmd.payload.limitView.limit  = pos;
      cmd.payload.limitView.unused = '0;
    end else begin
      cmd.payload.operandView.data     = data;
      cmd.payload.operandView.position = pos;
    end
    cmdValid = 1'b1;
    stepModel(op, data, pos, 1'b1);
  endtask

  task automatic idleCycle();
    @(negedge clk);
    cmdValid = 1'b0;
    stepModel(cmdNone, 0, 0, 1'b0);
  endtask

  task automatic drainPipeline();
    repeat (3) idleCycle();
  endtask

  task automatic startTest(input string name);
    testName    = name;
    failAtStart = failCount;
  endtask

  task automatic finishTest();
    drainPipeline();
    if (failCount == failAtStart) begin
      passTests++;
      $display("test %-10s ok", testName);
    end else begin
      failTests++;
      $display("test %-10s %0d errors", testName, failCount - failAtStart);
    end
  endtask

  indexCheck: assert property (@(posedge clk) disable iff (reset)
    pipeB.valid |-> (stackIndex == pipeB.index))
    else reportMismatch("index", $sampled(pipeB.index), $sampled(stackIndex));

  statusCheck: assert property (@(posedge clk) disable iff (reset)
    pipeB.valid |-> (status == pipeB.status))
    else reportMismatch("status", $sampled(pipeB.status), $sampled(status));

  topCheck: assert property (@(posedge clk) disable iff (reset)
    (pipeB.valid && pipeB.topKnown) |-> (stackTop == pipeB.top))
    else reportMismatch("top", $sampled(pipeB.top), $sampled(stackTop));

  pulseCheck: assert property (@(posedge clk) disable iff (reset)
    pipeB.valid |-> (errorPulse == pipeB.pulse))
    else reportMismatch("errorPulse", $sampled(pipeB.pulse), $sampled(errorPulse));

  countCheck: assert property (@(posedge clk) disable iff (reset)
    pipeB.valid |-> (errorCount == pipeB.count))
    else reportMismatch("errorCount", $sampled(pipeB.count), $sampled(errorCount));

  initial begin
    logic [31:0] randData;
    reset       = 1'b1;
    cmdValid    = 1'b0;
    cmd         = '0;
    expNow      = '0;
    memKnown    = '0;
    modelTop    = '0;
    topKnown    = 1'b0;
    modelIndex  = 0;
    modelLimit  = 0;
    modelErrors = 0;
    failCount   = 0;
    failAtStart = 0;
    passTests   = 0;
    failTests   = 0;
    pulseSeen   = 0;
    seed        = 5;
    testName    = "reset";
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    startTest("reset");
    issueCommand(cmdNone, 8'd0, 5'd0);
    finishTest();

    startTest("lifo");
    for (int i = 0; i < 6; i++) begin
      randData = $random(seed);
      issueCommand(cmdPush, randData[7:0], 5'd0);
    end
    issueCommand(cmdPop, 8'd0, 5'd0);
    issueCommand(cmdPop, 8'd2, 5'd0);
    randData = $random(seed);
    issueCommand(cmdReplace, randData[7:0], 5'd0);
    finishTest();

    startTest("full");
    issueCommand(cmdIndexReset, 8'd0, 5'd0);
    for (int i = 0; i < 17; i++) begin
      randData = $random(seed);
      issueCommand(cmdPush, randData[7:0], 5'd0);
    end
    finishTest();

    startTest("limit");
    issueCommand(cmdIndexReset, 8'd0, 5'd4);
    issueCommand(cmdSetLimit, 8'd0, 5'd4);
    issueCommand(cmdNone, 8'd0, 5'd0);     // Refresh with the new limit
    issueCommand(cmdPop, 8'd0, 5'd0);
    issueCommand(cmdReplace, 8'h5A, 5'd0);
    issueCommand(cmdPoke, 8'h3C, 5'd1);    // Lower entry, stack stays empty
    issueCommand(cmdPush, 8'hC3, 5'd0);
    issueCommand(cmdPop, 8'd1, 5'd0);
    issueCommand(cmdSetLimit, 8'd0, 5'd0);
    issueCommand(cmdNone, 8'd0, 5'd0);
    finishTest();

    startTest("peekPoke");
    issueCommand(cmdPeek, 8'd0, 5'd2);
    randData = $random(seed);
    issueCommand(cmdPoke, randData[7:0], 5'd4);
    randData = $random(seed);
    issueCommand(cmdPoke, randData[7:0], 5'd1);
    issueCommand(cmdPeek, 8'd0, 5'd1);
    issueCommand(cmdPeek, 8'd0, 5'd5);
    issueCommand(cmdPoke, 8'h11, 5'd7);
    finishTest();

    startTest("indexReset");
    issueCommand(cmdIndexReset, 8'd0, 5'd3);
    issueCommand(cmdIndexReset, 8'd0, 5'd10);
    issueCommand(cmdIndexResetPush, 8'h77, 5'd9);
    randData = $random(seed);
    issueCommand(cmdIndexResetPush, randData[7:0], 5'd2);
    drainPipeline();
    pulseTotal: assert (pulseSeen == modelErrors)
      else reportMismatch("errorPulse total", modelErrors, pulseSeen);
    finishTest();

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             passTests, failTests, failCount);
    if (failCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Four clock periods per command leaves room for reset and draining
  initial begin
    #(totalCommands * 20 * 4);
    $display("watchdog: run did not finish within %0d ns", totalCommands * 20 * 4);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* logic/stackUnit.sv */
`timescale 1ns/100ps

`include "stack_cfg.svh"

module stackUnit
  import stackPkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          cmdValid,
  input  cmdWord_s                      cmd,
  output logic [`STACK_INDEX_WIDTH-1:0] stackIndex,
  output logic [`STACK_DATA_WIDTH-1:0]  stackTop,
  output stackStatus_e                  status,
  output logic                          errorPulse,
  output logic [7:0]                    errorCount
);

  coreOp_e                       coreOp;
  logic [`STACK_DATA_WIDTH-1:0]  coreData;
  logic [`STACK_INDEX_WIDTH-1:0] corePosition;
  logic [`STACK_INDEX_WIDTH-1:0] underflowLimit;
  logic [`STACK_INDEX_WIDTH-1:0] coreIndex;
  logic [`STACK_DATA_WIDTH-1:0]  coreTop;
  stackStatus_e                  coreStatus;
  logic                          cmdDone;

  commandDecoder decoder (
    .clk            (clk),
    .reset          (reset),
    .cmdValid       (cmdValid),
    .cmd            (cmd),
    .coreOp         (coreOp),
    .coreData       (coreData),
    .corePosition   (corePosition),
    .underflowLimit (underflowLimit)
  );

  operandStack core (
    .clk            (clk),
    .reset          (reset),
    .op             (coreOp),
    .data           (coreData),
    .position       (corePosition),
    .underflowLimit (underflowLimit),
    .index          (coreIndex),
    .top            (coreTop),
    .coreStatus     (coreStatus),
    .cmdDone        (cmdDone)
  );

  statusReporter reporter (
    .clk        (clk),
    .reset      (reset),
    .index      (coreIndex),
    .top        (coreTop),
    .coreStatus (coreStatus),
    .cmdDone    (cmdDone),
    .stackIndex (stackIndex),
    .stackTop   (stackTop),
    .status     (status),
    .errorPulse (errorPulse),
    .errorCount (errorCount)
  );

endmodule

/* logic/statusReporter.sv */
`timescale 1ns/100ps

`include "stack_cfg.svh"

module statusReporter
  import stackPkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`STACK_INDEX_WIDTH-1:0] index,
  input  logic [`STACK_DATA_WIDTH-1:0]  top,
  input  stackStatus_e                  coreStatus,
  input  logic                          cmdDone,
  output logic [`STACK_INDEX_WIDTH-1:0] stackIndex,
  output logic [`STACK_DATA_WIDTH-1:0]  stackTop,
  output stackStatus_e                  status,
  output logic                          errorPulse,
  output logic [7:0]                    errorCount
);

  logic isError;
  logic errorHit;

  // Empty and full are plain states, not faults
  assign isError  = coreStatus inside {statOverflow, statUnderflow,
                                       statBadIndex, statBadOffset};
  assign errorHit = cmdDone && isError;

  always_ff @(posedge clk) begin
    stackTop <= top;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stackIndex <= '0;
      status     <= statEmpty;
      errorPulse <= 1'b0;
    end else begin
      stackIndex <= index;
      status     <= coreStatus;
      errorPulse <= errorHit;
    end
  end

  // Count sticks at its maximum
  always_ff @(posedge clk) begin
    if (reset) begin
      errorCount <= '0;
    end else if (errorHit && (errorCount != 8'hFF)) begin
      errorCount <= errorCount + 1'b1;
    end
  end

  countMonotonic: assert property (
    @(posedge clk) disable iff (reset)
    !$past(reset) |-> (errorCount >= $past(errorCount))
  ) else $error("statusReporter: errorCount went down");

endmodule

/* logic/operandStack.sv */
`timescale 1ns/100ps

`include "stack_cfg.svh"

module operandStack
  import stackPkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  coreOp_e                       op,
  input  logic [`STACK_DATA_WIDTH-1:0]  data,
  input  logic [`STACK_INDEX_WIDTH-1:0] position,
  input  logic [`STACK_INDEX_WIDTH-1:0] underflowLimit,
  output logic [`STACK_INDEX_WIDTH-1:0] index,
  output logic [`STACK_DATA_WIDTH-1:0]  top,
  output stackStatus_e                  coreStatus,
  output logic                          cmdDone
);

  localparam logic [`STACK_INDEX_WIDTH-1:0] fullIndex = `STACK_CAPACITY;

  logic [`STACK_DATA_WIDTH-1:0] mem [`STACK_CAPACITY];

  logic [`STACK_INDEX_WIDTH-1:0] nextIndex;
  stackStatus_e                  nextStatus;
  logic                          writeEn;
  logic [`STACK_DEPTH_LOG2-1:0]  writeAddr;
  logic [`STACK_DEPTH_LOG2-1:0]  readAddr;
  logic                          topLoad;
  logic                          topFromData;
  logic [`STACK_INDEX_WIDTH-1:0] indexLast;    // Slot of the current top
  logic [`STACK_INDEX_WIDTH-1:0] positionLast;
  logic [`STACK_INDEX_WIDTH-1:0] popIndex;
  logic [`STACK_INDEX_WIDTH-1:0] popLast;
  logic [`STACK_DATA_WIDTH:0]    popSpan;      // Count plus limit without wrap
  logic                          popOk;

  // Status of a stack sitting at idx
  function automatic stackStatus_e getStatus(input logic [`STACK_INDEX_WIDTH-1:0] idx,
                                             input logic [`STACK_INDEX_WIDTH-1:0] limit);
    if (idx == fullIndex) begin
      return statFull;
    end else if (idx == limit) begin
      return statEmpty;
    end else if (idx < limit) begin
      return statUnderflow;
    end
    return statNone;
  endfunction

  assign indexLast    = index - 1'b1;
  assign positionLast = position - 1'b1;
  assign popSpan      = {1'b0, data} + underflowLimit;
  assign popOk        = index > popSpan; // Must stay above the limit
  assign popIndex     = index - data[`STACK_INDEX_WIDTH-1:0] - 1'b1;
  assign popLast      = popIndex - 1'b1;

  always_comb begin
    nextIndex   = index;
    nextStatus  = getStatus(index, underflowLimit);
    writeEn     = 1'b0;
    writeAddr   = index[`STACK_DEPTH_LOG2-1:0];
    readAddr    = indexLast[`STACK_DEPTH_LOG2-1:0];
    topLoad     = 1'b0;
    topFromData = 1'b0;

    // Refused operations only touch the status
    case (op)
      coreNone: begin
        topLoad = 1'b1;
      end
      corePush: begin
        if (index == fullIndex) begin
          nextStatus = statOverflow;
        end else begin
          writeEn     = 1'b1;
          nextIndex   = index + 1'b1;
          topLoad     = 1'b1;
          topFromData = 1'b1;
          nextStatus  = getStatus(index + 1'b1, underflowLimit);
        end
      end
      corePop: begin
        if (!popOk) begin
          nextStatus = statUnderflow;
        end else begin
          nextIndex  = popIndex;
          readAddr   = popLast[`STACK_DEPTH_LOG2-1:0];
          topLoad    = 1'b1;
          nextStatus = getStatus(popIndex, underflowLimit);
        end
      end
      coreReplace: begin
        if (index <= underflowLimit) begin
          nextStatus = statUnderflow;
        end else begin
          writeEn     = 1'b1;
          writeAddr   = indexLast[`STACK_DEPTH_LOG2-1:0];
          topLoad     = 1'b1;
          topFromData = 1'b1;
        end
      end
      coreIndexReset: begin
        if (position > index) begin
          nextStatus = statBadIndex;
        end else begin
          nextIndex  = position;
          readAddr   = positionLast[`STACK_DEPTH_LOG2-1:0];
          topLoad    = 1'b1;
          nextStatus = getStatus(position, underflowLimit);
        end
      end
      coreIndexResetPush: begin
        if (position > index) begin
          nextStatus = statBadIndex;
        end else if (position == fullIndex) begin
          nextStatus = statOverflow;
        end else begin
          writeEn     = 1'b1;
          writeAddr   = position[`STACK_DEPTH_LOG2-1:0];
          nextIndex   = position + 1'b1;
          topLoad     = 1'b1;
          topFromData = 1'b1;
          nextStatus  = getStatus(position + 1'b1, underflowLimit);
        end
      end
      corePeek: begin
        if (position >= index) begin
          nextStatus = statBadOffset;
        end else begin
          readAddr   = position[`STACK_DEPTH_LOG2-1:0];
          topLoad    = 1'b1;
          nextStatus = statNone;
        end
      end
      corePoke: begin
        if (position >= index) begin
          nextStatus = statBadOffset;
        end else begin
          writeEn   = 1'b1;
          writeAddr = position[`STACK_DEPTH_LOG2-1:0];
          if (position == indexLast) begin // Top entry rewritten
            topLoad     = 1'b1;
            topFromData = 1'b1;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[writeAddr] <= data;
    end
  end

  // New top comes from the write data when that slot is being written
  always_ff @(posedge clk) begin
    if (topLoad) begin
      top <= topFromData ? data : mem[readAddr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      index      <= '0;
      coreStatus <= statEmpty;
      cmdDone    <= 1'b0;
    end else begin
      index      <= nextIndex;
      coreStatus <= nextStatus;
      cmdDone    <= (op != coreNone); // Idle refresh is not a command
    end
  end

  indexInRange: assert property (
    @(posedge clk) disable iff (reset)
    index <= fullIndex
  ) else $error("operandStack: index %0d past capacity", index);

  pushAtFullHolds: assert property (
    @(posedge clk) disable iff (reset)
    (op == corePush && index == fullIndex) |=> $stable(index)
  ) else $error("operandStack: index moved on push at full");

endmodule

/* logic/commandDecoder.sv */
`timescale 1ns/100ps

`include "stack_cfg.svh"

module commandDecoder
  import stackPkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          cmdValid,
  input  cmdWord_s                      cmd,
  output coreOp_e                       coreOp,
  output logic [`STACK_DATA_WIDTH-1:0]  coreData,
  output logic [`STACK_INDEX_WIDTH-1:0] corePosition,
  output logic [`STACK_INDEX_WIDTH-1:0] underflowLimit
);

  logic isStackOp;
  logic isSetLimit;

  // Opcodes 0..7 go straight to the core
  assign isStackOp  = cmdValid && (cmd.opcode <= cmdPoke);
  assign isSetLimit = cmdValid && (cmd.opcode == cmdSetLimit);

  always_comb begin
    coreOp       = coreNone; // Idle cycles refresh the top
    coreData     = cmd.payload.operandView.data;
    corePosition = cmd.payload.operandView.position;
    if (isStackOp) begin
      coreOp = coreOp_e'(cmd.opcode[2:0]);
    end
  end

  // Limit is part of the stack state, loaded by its own command
  always_ff @(posedge clk) begin
    if (reset) begin
      underflowLimit <= '0;
    end else if (isSetLimit) begin
      underflowLimit <= cmd.payload.limitView.limit;
    end
  end

  // Opcodes past cmdSetLimit are not defined
  validOpcode: assert property (
    @(posedge clk) disable iff (reset)
    cmdValid |-> (cmd.opcode <= cmdSetLimit)
  ) else $error("commandDecoder: undefined opcode %0d", cmd.opcode);

endmodule

/* logic/stackPkg.sv */
`include "stack_cfg.svh"

package stackPkg;

  // External command opcodes, 0..7 match the core operations one to one
  typedef enum logic [3:0] {
    cmdNone           = 4'd0,
    cmdPush           = 4'd1,
    cmdPop            = 4'd2,
    cmdReplace        = 4'd3,
    cmdIndexReset     = 4'd4,
    cmdIndexResetPush = 4'd5,
    cmdPeek           = 4'd6,
    cmdPoke           = 4'd7,
    cmdSetLimit       = 4'd8
  } cmdOp_e;

  typedef enum logic [2:0] {
    coreNone           = 3'd0,
    corePush           = 3'd1,
    corePop            = 3'd2,
    coreReplace        = 3'd3,
    coreIndexReset     = 3'd4,
    coreIndexResetPush = 3'd5,
    corePeek           = 3'd6,
    corePoke           = 3'd7
  } coreOp_e;

  typedef enum logic [2:0] {
    statNone      = 3'd0,
    statEmpty     = 3'd1,
    statFull      = 3'd2,
    statUnderflow = 3'd3,
    statOverflow  = 3'd4,
    statBadIndex  = 3'd5,
    statBadOffset = 3'd6
  } stackStatus_e;

  typedef struct packed {
    logic [`STACK_DATA_WIDTH-1:0]  data;
    logic [`STACK_INDEX_WIDTH-1:0] position; // New index or offset
  } operandView_s;

  typedef struct packed {
    logic [`STACK_INDEX_WIDTH-1:0] limit;
    logic [`STACK_DATA_WIDTH-1:0]  unused;
  } limitView_s;

  // Same payload bits, decoded by opcode
  typedef union packed {
    operandView_s operandView;
    limitView_s   limitView;
  } cmdPayload_u;

  typedef struct packed {
    cmdOp_e      opcode;
    cmdPayload_u payload;
  } cmdWord_s;

endpackage

/* logic/stack_cfg.svh */
`ifndef STACK_CFG_SVH
`define STACK_CFG_SVH

// Width of one stack word
`define STACK_DATA_WIDTH 8

// Capacity is 2**STACK_DEPTH_LOG2 entries
`define STACK_DEPTH_LOG2 4

// One extra bit so an index can reach the full mark
`define STACK_INDEX_WIDTH 5

`define STACK_CAPACITY 16

`endif
